// File: src/periph_map_pkg.sv
// peripheral address map
`default_nettype none

package periph_map_pkg;

   // host bus
   localparam int HID_ADDR_W = 18;
   localparam int HID_DATA_W = 64;
   localparam int HID_BE_W   = 8;

   // regions selected by address bits 17:15
   localparam int REGION_CTRL = 2;
   localparam int REGION_UART = 6;

   // control region word offsets
   localparam logic [4:0] CTRL_LED_OFS = 5'd15;
   localparam logic [4:0] CTRL_DIP_OFS = 5'd31;

   localparam logic [HID_DATA_W-1:0] CTRL_UNMAPPED = 64'h0000_0000_dead_beef;

   localparam int LED_W = 22;
   localparam int DIP_W = 16;

   // one host address seen by the control region and by the UART
   typedef union packed {
      struct packed {
         logic [2:0] region;
         logic [6:0] unused_hi;
         logic [4:0] word_ofs;     // 64-bit word index
         logic [2:0] unused_lo;    // byte lane bits
      } ctrl;
      struct packed {
         logic [2:0]  region;
         logic        uart_en;     // low selects the old keyboard slot
         logic [1:0]  sel;         // register selector
         logic [11:0] unused;
      } uart;
   } hid_addr_u;

endpackage

`default_nettype wire

// File: src/uart_pkg.sv
// uart constants and register layout
`default_nettype none

package uart_pkg;

   localparam int UART_DATA_W = 8;

   localparam int                BAUD_W       = 16;
   localparam logic [BAUD_W-1:0] BAUD_DEFAULT = 16'd54;   // clocks per bit

   localparam int FIFO_DEPTH_LOG2 = 4;
   localparam int CNT_W           = 12;

   // register selectors, address bits 13:12
   localparam logic [1:0] UART_SEL_PUSH = 2'd0;
   localparam logic [1:0] UART_SEL_POP  = 2'd1;
   localparam logic [1:0] UART_SEL_BAUD = 2'd2;

   localparam int RX_ENTRY_W = 9;   // error flag over data byte

   // status word
   localparam int ST_RX_BYTE_LSB  = 0;
   localparam int ST_RX_ERR_BIT   = 8;
   localparam int ST_RX_EMPTY_BIT = 9;
   localparam int ST_TX_FULL_BIT  = 10;
   localparam int ST_RX_FULL_BIT  = 11;

   // count word, one 16-bit lane per counter
   localparam int CNT_LANE_W     = 16;
   localparam int CNT_LANE_RX_RD = 0;
   localparam int CNT_LANE_RX_WR = 1;
   localparam int CNT_LANE_TX_RD = 2;
   localparam int CNT_LANE_TX_WR = 3;

   // receiver states
   localparam logic [1:0] RX_IDLE  = 2'd0;
   localparam logic [1:0] RX_START = 2'd1;
   localparam logic [1:0] RX_DATA  = 2'd2;
   localparam logic [1:0] RX_STOP  = 2'd3;

endpackage

`default_nettype wire

// File: src/sync_fifo.sv
// single clock fifo
`default_nettype none

module sync_fifo #(
   parameter int WIDTH      = 8,
   parameter int DEPTH_LOG2 = 4
) (
   input  logic                       msoc_clk,
   input  logic                       rstn,
   input  logic                       push_i,
   input  logic                       pop_i,
   input  logic [WIDTH-1:0]           din_i,
   output logic [WIDTH-1:0]           dout_o,
   output logic                       full_o,
   output logic                       empty_o,
   output logic [uart_pkg::CNT_W-1:0] wr_count_o,
   output logic [uart_pkg::CNT_W-1:0] rd_count_o
);

   import uart_pkg::*;

   localparam int DEPTH = 1 << DEPTH_LOG2;

   logic [WIDTH-1:0] mem [DEPTH];
   logic [CNT_W-1:0] wr_ptr;
   logic [CNT_W-1:0] rd_ptr;
   logic [CNT_W-1:0] fill;
   logic             push_ok;
   logic             pop_ok;

   // pointers run free, the fill level is their difference
   assign fill    = wr_ptr - rd_ptr;
   assign empty_o = (fill == '0);
   assign full_o  = (fill == CNT_W'(DEPTH));

   assign push_ok = push_i & ~full_o;   // push into a full fifo is lost
   assign pop_ok  = pop_i & ~empty_o;

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (push_ok)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop_ok)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (push_ok)
         mem[wr_ptr[DEPTH_LOG2-1:0]] <= din_i;
   end

   assign dout_o     = mem[rd_ptr[DEPTH_LOG2-1:0]];   // show-ahead head
   assign wr_count_o = wr_ptr;
   assign rd_count_o = rd_ptr;

endmodule

`default_nettype wire

// File: src/uart_core.sv
// uart serializer and deserializer
`default_nettype none

module uart_core (
   input  logic                            msoc_clk,
   input  logic                            rstn,
   input  logic [uart_pkg::BAUD_W-1:0]     baud_i,
   input  logic                            tx_valid_i,
   input  logic [uart_pkg::UART_DATA_W-1:0] tx_data_i,
   output logic                            tx_ready_o,
   output logic                            tx_o,
   input  logic                            rx_i,
   output logic                            rx_valid_o,
   output logic [uart_pkg::UART_DATA_W-1:0] rx_data_o,
   output logic                            rx_err_o
);

   import uart_pkg::*;

   logic [2:0]             rx_filt;
   logic                   rx_maj;
   logic                   rx_prev;
   logic [1:0]             rx_state;
   logic [BAUD_W-1:0]      rx_timer;
   logic [2:0]             rx_bits;
   logic [UART_DATA_W-1:0] rx_shift;
   logic                   rx_sample;

   logic                   tx_busy;
   logic [BAUD_W-1:0]      tx_timer;
   logic [3:0]             tx_bits;
   logic [UART_DATA_W+1:0] tx_shift;

   // three sample majority vote on the line
   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
         rx_filt <= '1;
      else
         rx_filt <= {rx_filt[1:0], rx_i};
   end

   assign rx_maj = (rx_filt[0] & rx_filt[1]) | (rx_filt[0] & rx_filt[2]) |
                   (rx_filt[1] & rx_filt[2]);

   // transmitter
   assign tx_ready_o = ~tx_busy;
   assign tx_o       = tx_shift[0];

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         tx_busy  <= 1'b0;
         tx_timer <= '0;
         tx_bits  <= '0;
         tx_shift <= '1;   // line idles high
      end
      else if (!tx_busy)
      begin
         if (tx_valid_i)
         begin
            tx_busy  <= 1'b1;
            tx_timer <= baud_i - 1'b1;
            tx_bits  <= 4'd9;                    // bits after the start bit
            tx_shift <= {1'b1, tx_data_i, 1'b0}; // stop, data, start
         end
      end
      else if (tx_timer != '0)
         tx_timer <= tx_timer - 1'b1;
      else
      begin
         tx_timer <= baud_i - 1'b1;
         tx_shift <= {1'b1, tx_shift[UART_DATA_W+1:1]};
         if (tx_bits == '0)
            tx_busy <= 1'b0;                     // stop bit done
         else
            tx_bits <= tx_bits - 1'b1;
      end
   end

   // receiver
   assign rx_sample = (rx_state == RX_DATA) && (rx_timer == '0);
   assign rx_data_o = rx_shift;

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         rx_prev    <= 1'b1;
         rx_state   <= RX_IDLE;
         rx_timer   <= '0;
         rx_bits    <= '0;
         rx_valid_o <= 1'b0;
         rx_err_o   <= 1'b0;
      end
      else
      begin
         rx_prev    <= rx_maj;
         rx_valid_o <= 1'b0;
         case (rx_state)
            RX_IDLE:
               if (rx_prev & ~rx_maj)                       // falling edge only
               begin
                  rx_state <= RX_START;
                  rx_timer <= {1'b0, baud_i[BAUD_W-1:1]};  // wait half a bit
               end
            RX_START:
               if (rx_timer != '0)
                  rx_timer <= rx_timer - 1'b1;
               else if (!rx_maj)
               begin
                  rx_state <= RX_DATA;
                  rx_timer <= baud_i - 1'b1;
                  rx_bits  <= '0;
               end
               else
                  rx_state <= RX_IDLE;                     // glitch, not a start
            RX_DATA:
               if (rx_timer != '0)
                  rx_timer <= rx_timer - 1'b1;
               else
               begin
                  rx_timer <= baud_i - 1'b1;
                  rx_bits  <= rx_bits + 1'b1;
                  if (rx_bits == 3'd7)
                     rx_state <= RX_STOP;
               end
            RX_STOP:
               if (rx_timer != '0)
                  rx_timer <= rx_timer - 1'b1;
               else
               begin
                  rx_valid_o <= 1'b1;
                  rx_err_o   <= ~rx_maj;                   // stop bit must be high
                  rx_state   <= RX_IDLE;
               end
            default:
               rx_state <= RX_IDLE;
         endcase
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (rx_sample)
         rx_shift <= {rx_maj, rx_shift[UART_DATA_W-1:1]};   // lsb first
   end

endmodule

`default_nettype wire

// File: src/uart_ctrl.sv
// uart registers and fifos
`default_nettype none

module uart_ctrl (
   input  logic                                msoc_clk,
   input  logic                                rstn,
   input  logic                                uart_wr_en_i,
   input  logic [1:0]                          uart_sel_i,
   input  logic                                uart_rd_sel_i,
   input  logic [periph_map_pkg::HID_DATA_W-1:0] wrdata_i,
   output logic [periph_map_pkg::HID_DATA_W-1:0] uart_rdata_o,
   input  logic                                uart_rx_i,
   output logic                                uart_tx_o,
   output logic                                uart_irq_o
);

   import uart_pkg::*;

   logic [BAUD_W-1:0]      baud_q;
   logic                   tx_push;
   logic                   rx_pop;
   logic                   baud_load;

   logic [UART_DATA_W-1:0] tx_head;
   logic                   tx_empty;
   logic                   tx_full;
   logic                   tx_ready;
   logic                   tx_fire;
   logic [CNT_W-1:0]       tx_wr_count;
   logic [CNT_W-1:0]       tx_rd_count;

   logic [RX_ENTRY_W-1:0]  rx_head;
   logic                   rx_empty;
   logic                   rx_full;
   logic                   rx_valid;
   logic [UART_DATA_W-1:0] rx_data;
   logic                   rx_err;
   logic [CNT_W-1:0]       rx_wr_count;
   logic [CNT_W-1:0]       rx_rd_count;

   assign tx_push   = uart_wr_en_i & (uart_sel_i == UART_SEL_PUSH);
   assign rx_pop    = uart_wr_en_i & (uart_sel_i == UART_SEL_POP);
   assign baud_load = uart_wr_en_i & (uart_sel_i == UART_SEL_BAUD);

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
         baud_q <= BAUD_DEFAULT;
      else if (baud_load)
         baud_q <= wrdata_i[BAUD_W-1:0];
   end

   // head leaves the fifo when the core takes it
   assign tx_fire = ~tx_empty & tx_ready;

   sync_fifo #(.WIDTH(UART_DATA_W), .DEPTH_LOG2(FIFO_DEPTH_LOG2)) tx_fifo (
      .msoc_clk   (msoc_clk),
      .rstn       (rstn),
      .push_i     (tx_push),
      .pop_i      (tx_fire),
      .din_i      (wrdata_i[UART_DATA_W-1:0]),
      .dout_o     (tx_head),
      .full_o     (tx_full),
      .empty_o    (tx_empty),
      .wr_count_o (tx_wr_count),
      .rd_count_o (tx_rd_count)
   );

   uart_core core (
      .msoc_clk   (msoc_clk),
      .rstn       (rstn),
      .baud_i     (baud_q),
      .tx_valid_i (~tx_empty),
      .tx_data_i  (tx_head),
      .tx_ready_o (tx_ready),
      .tx_o       (uart_tx_o),
      .rx_i       (uart_rx_i),
      .rx_valid_o (rx_valid),
      .rx_data_o  (rx_data),
      .rx_err_o   (rx_err)
   );

   // no back-pressure, a byte into a full fifo is dropped
   sync_fifo #(.WIDTH(RX_ENTRY_W), .DEPTH_LOG2(FIFO_DEPTH_LOG2)) rx_fifo (
      .msoc_clk   (msoc_clk),
      .rstn       (rstn),
      .push_i     (rx_valid),
      .pop_i      (rx_pop),
      .din_i      ({rx_err, rx_data}),
      .dout_o     (rx_head),
      .full_o     (rx_full),
      .empty_o    (rx_empty),
      .wr_count_o (rx_wr_count),
      .rd_count_o (rx_rd_count)
   );

   assign uart_irq_o = ~rx_empty;

   always_comb
   begin
      uart_rdata_o = '0;
      if (uart_rd_sel_i)
      begin
         uart_rdata_o[CNT_LANE_RX_RD*CNT_LANE_W +: CNT_W] = rx_rd_count;
         uart_rdata_o[CNT_LANE_RX_WR*CNT_LANE_W +: CNT_W] = rx_wr_count;
         uart_rdata_o[CNT_LANE_TX_RD*CNT_LANE_W +: CNT_W] = tx_rd_count;
         uart_rdata_o[CNT_LANE_TX_WR*CNT_LANE_W +: CNT_W] = tx_wr_count;
      end
      else
      begin
         uart_rdata_o[ST_RX_BYTE_LSB +: UART_DATA_W] = rx_head[UART_DATA_W-1:0];
         uart_rdata_o[ST_RX_ERR_BIT]   = rx_head[RX_ENTRY_W-1];
         uart_rdata_o[ST_RX_EMPTY_BIT] = rx_empty;
         uart_rdata_o[ST_TX_FULL_BIT]  = tx_full;
         uart_rdata_o[ST_RX_FULL_BIT]  = rx_full;
      end
   end

endmodule

`default_nettype wire

// File: src/periph_soc.sv
// peripheral block top
`default_nettype none

module periph_soc (
   input  logic                                  msoc_clk,
   input  logic                                  rstn,
   input  logic                                  hid_en_i,
   input  logic [periph_map_pkg::HID_BE_W-1:0]   hid_we_i,
   input  logic [periph_map_pkg::HID_ADDR_W-1:0] hid_addr_i,
   input  logic [periph_map_pkg::HID_DATA_W-1:0] hid_wrdata_i,
   output logic [periph_map_pkg::HID_DATA_W-1:0] hid_rddata_o,
   input  logic [periph_map_pkg::DIP_W-1:0]      from_dip_i,
   output logic [periph_map_pkg::LED_W-1:0]      to_led_o,
   input  logic                                  uart_rx_i,
   output logic                                  uart_tx_o,
   output logic                                  uart_irq_o
);

   import periph_map_pkg::*;

   hid_addr_u             addr_v;
   logic [7:0]            region_hot;
   logic [HID_DATA_W-1:0] region_rdata [8];
   logic                  host_wr;
   logic                  uart_wr_en;
   logic [HID_DATA_W-1:0] uart_rdata;
   logic [HID_DATA_W-1:0] ctrl_rdata;
   logic [DIP_W-1:0]      dip_q;

   assign addr_v     = hid_addr_i;
   assign host_wr    = hid_en_i & (|hid_we_i);
   assign uart_wr_en = host_wr & region_hot[REGION_UART] & addr_v.uart.uart_en;

   uart_ctrl uart (
      .msoc_clk      (msoc_clk),
      .rstn          (rstn),
      .uart_wr_en_i  (uart_wr_en),
      .uart_sel_i    (addr_v.uart.sel),
      .uart_rd_sel_i (addr_v.uart.sel[1]),   // address bit 13
      .wrdata_i      (hid_wrdata_i),
      .uart_rdata_o  (uart_rdata),
      .uart_rx_i     (uart_rx_i),
      .uart_tx_o     (uart_tx_o),
      .uart_irq_o    (uart_irq_o)
   );

   // led register and dip snapshot
   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         to_led_o <= '0;
         dip_q    <= '0;
      end
      else
      begin
         dip_q <= from_dip_i;
         if (host_wr && region_hot[REGION_CTRL] && addr_v.ctrl.word_ofs == CTRL_LED_OFS)
            to_led_o <= hid_wrdata_i[LED_W-1:0];
      end
   end

   always_comb
   begin
      case (addr_v.ctrl.word_ofs)
         CTRL_LED_OFS: ctrl_rdata = HID_DATA_W'(to_led_o);
         CTRL_DIP_OFS: ctrl_rdata = HID_DATA_W'(dip_q);
         default:      ctrl_rdata = CTRL_UNMAPPED;
      endcase
   end

   always_comb
   begin
      region_rdata              = '{default: '0};
      region_rdata[REGION_CTRL] = ctrl_rdata;
      region_rdata[REGION_UART] = addr_v.uart.uart_en ? uart_rdata : '0;   // keyboard slot reads 0
   end

   // one-hot decode, or-combined read data
   always_comb
   begin
      hid_rddata_o = '0;
      for (int i = 0; i < 8; i++)
      begin
         region_hot[i] = (addr_v.ctrl.region == 3'(i));
         hid_rddata_o  = hid_rddata_o | (region_hot[i] ? region_rdata[i] : '0);
      end
   end

endmodule

`default_nettype wire

// File: tb/periph_soc_properties.sv
// peripheral block port checks
`default_nettype none

module periph_soc_properties (
   input logic                                  msoc_clk,
   input logic                                  rstn,
   input logic [periph_map_pkg::HID_ADDR_W-1:0] hid_addr_i,
   input logic [periph_map_pkg::HID_DATA_W-1:0] hid_rddata_o,
   input logic                                  uart_tx_o,
   input logic                                  uart_irq_o
);

   timeunit 1ns;
   timeprecision 1ps;

   import periph_map_pkg::*;
   import uart_pkg::*;

   hid_addr_u addr_v;
   logic      status_sel;
   logic      mapped;
   int        fail_count = 0;   // failed assertions, read by the testbench

   assign addr_v     = hid_addr_i;
   assign status_sel = (addr_v.uart.region == 3'(REGION_UART)) && addr_v.uart.uart_en &&
                       !addr_v.uart.sel[1];   // bit 13 low selects the status word
   assign mapped     = (addr_v.ctrl.region == 3'(REGION_CTRL)) ||
                       (addr_v.ctrl.region == 3'(REGION_UART));

   // serial line idles high while in reset
   tx_idle_in_reset: assert property (@(posedge msoc_clk) !rstn |-> uart_tx_o)
      else
      begin
         $error("uart_tx_o low during reset");
         fail_count++;
      end

   irq_tracks_rx_empty: assert property (@(posedge msoc_clk) disable iff (!rstn)
      status_sel |-> (uart_irq_o == !hid_rddata_o[ST_RX_EMPTY_BIT]))
      else
      begin
         $error("uart_irq_o disagrees with rx empty status");
         fail_count++;
      end

   unmapped_reads_zero: assert property (@(posedge msoc_clk) disable iff (!rstn)
      !mapped |-> (hid_rddata_o == '0))
      else
      begin
         $error("unmapped region returned nonzero read data");
         fail_count++;
      end

endmodule

`default_nettype wire

// File: tb/periph_soc_tb.sv
// peripheral block testbench
`default_nettype none

module periph_soc_tb;

   timeunit 1ns;
   timeprecision 1ps;

   import periph_map_pkg::*;
   import uart_pkg::*;

   localparam int CLK_PERIOD = 20;
   localparam int FRAME_BAUD = 16;

   logic                  msoc_clk;
   logic                  rstn;
   logic                  hid_en;
   logic [HID_BE_W-1:0]   hid_we;
   logic [HID_ADDR_W-1:0] hid_addr;
   logic [HID_DATA_W-1:0] hid_wrdata;
   logic [HID_DATA_W-1:0] hid_rddata;
   logic [DIP_W-1:0]      from_dip;
   logic [LED_W-1:0]      to_led;
   logic                  uart_tx;
   logic                  uart_irq;
   logic                  force_mode;   // testbench drives the rx line
   logic                  force_bit;
   wire                   rx_line;

   logic [RX_ENTRY_W-1:0] rx_q [$];   // expected rx fifo entries
   logic [CNT_W-1:0]      tx_wr_m;
   logic [CNT_W-1:0]      tx_rd_m;
   logic [CNT_W-1:0]      rx_wr_m;
   logic [CNT_W-1:0]      rx_rd_m;
   logic [LED_W-1:0]      led_m;
   int                    err_count;
   int                    test_base;
   int                    test_count;
   int                    bad_tests;

   assign rx_line = force_mode ? force_bit : uart_tx;   // loopback by default

   periph_soc uut (
      .msoc_clk     (msoc_clk),
      .rstn         (rstn),
      .hid_en_i     (hid_en),
      .hid_we_i     (hid_we),
      .hid_addr_i   (hid_addr),
      .hid_wrdata_i (hid_wrdata),
      .hid_rddata_o (hid_rddata),
      .from_dip_i   (from_dip),
      .to_led_o     (to_led),
      .uart_rx_i    (rx_line),
      .uart_tx_o    (uart_tx),
      .uart_irq_o   (uart_irq)
   );

   bind periph_soc periph_soc_properties props (
      .msoc_clk     (msoc_clk),
      .rstn         (rstn),
      .hid_addr_i   (hid_addr_i),
      .hid_rddata_o (hid_rddata_o),
      .uart_tx_o    (uart_tx_o),
      .uart_irq_o   (uart_irq_o)
   );

   initial
   begin
      msoc_clk = 1'b0;
      forever #(CLK_PERIOD/2) msoc_clk = ~msoc_clk;
   end

   function automatic logic [HID_ADDR_W-1:0] ctrl_addr(input logic [4:0] ofs);
      return {3'(REGION_CTRL), 7'd0, ofs, 3'd0};
   endfunction

   function automatic logic [HID_ADDR_W-1:0] uart_addr(input logic [1:0] sel);
      return {3'(REGION_UART), 1'b1, sel, 12'd0};
   endfunction

   // lanes from high to low: tx write, tx read, rx write, rx read
   function automatic logic [HID_DATA_W-1:0] count_word();
      return {4'h0, tx_wr_m, 4'h0, tx_rd_m, 4'h0, rx_wr_m, 4'h0, rx_rd_m};
   endfunction

   task automatic report_err(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
      $display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
      err_count++;
   endtask

   task automatic report_fail(input string what);
      $display("t=%0t %s", $time, what);
      err_count++;
   endtask

   task automatic end_test(input string name);
      test_count++;
      if (err_count == test_base)
         $display("test %s: ok", name);
      else
      begin
         bad_tests++;
         $display("test %s: %0d errors", name, err_count - test_base);
      end
      test_base = err_count;
   endtask

   // entered and left just after a falling edge
   task automatic bus_write(input logic [HID_ADDR_W-1:0] addr, input logic [63:0] data);
      hid_en     = 1'b1;
      hid_we     = '1;
      hid_addr   = addr;
      hid_wrdata = data;
      @(negedge msoc_clk);
      hid_en = 1'b0;
      hid_we = '0;
   endtask

   task automatic bus_read(input logic [HID_ADDR_W-1:0] addr, output logic [63:0] data);
      hid_addr = addr;
      #(CLK_PERIOD/4);
      data = hid_rddata;   // settled well before the rising edge
      @(negedge msoc_clk);
   endtask

   task automatic apply_reset();
      rstn = 1'b0;
      repeat (3) @(negedge msoc_clk);
      rstn    = 1'b1;
      tx_wr_m = '0;
      tx_rd_m = '0;
      rx_wr_m = '0;
      rx_rd_m = '0;
      led_m   = '0;
      rx_q.delete();
   endtask

   task automatic wait_rx_written(input logic [CNT_W-1:0] target, input int max_cycles);
      logic [63:0] w;
      int          n;
      n = 0;
      bus_read(uart_addr(2'b10), w);
      while (w[16 +: CNT_W] != target && n < max_cycles)
      begin
         bus_read(uart_addr(2'b10), w);
         n++;
      end
      if (w[16 +: CNT_W] != target)
         report_fail("timeout waiting for received bytes");
   endtask

   // pop every expected entry, then check empty, irq and counts
   task automatic drain_rx();
      logic [63:0]           w;
      logic [RX_ENTRY_W-1:0] e;
      while (rx_q.size() > 0)
      begin
         e = rx_q.pop_front();
         bus_read(uart_addr(2'b00), w);
         if (w[9:0] !== {1'b0, e})
            report_err("status rx entry", 64'(w[9:0]), 64'({1'b0, e}));
         bus_write(uart_addr(UART_SEL_POP), 64'd0);
         rx_rd_m = rx_rd_m + 12'd1;
      end
      bus_read(uart_addr(2'b00), w);
      if (w[ST_RX_EMPTY_BIT] !== 1'b1)
         report_fail("rx fifo still holds data after the last pop");
      if (uart_irq !== 1'b0)
         report_err("uart_irq_o", 64'(uart_irq), 64'd0);
      bus_read(uart_addr(2'b10), w);
      if (w !== count_word())
         report_err("count word", w, count_word());
   endtask

   task automatic send_frame(input logic [7:0] b, input logic stop, input int baud);
      logic [9:0] bits;
      bits = {stop, b, 1'b0};
      for (int i = 0; i < 10; i++)
      begin
         force_bit = bits[i];
         repeat (baud) @(negedge msoc_clk);
      end
      force_bit = 1'b1;
      repeat (baud) @(negedge msoc_clk);   // idle gap
   endtask

   task automatic test_after_reset();
      logic [63:0] w;
      logic [2:0]  region;
      bus_read(uart_addr(2'b00), w);
      if (w[11:9] !== 3'b001)
         report_err("status flags", 64'(w[11:9]), 64'd1);
      bus_read(uart_addr(2'b10), w);
      if (w !== count_word())
         report_err("count word", w, count_word());
      if (uart_irq !== 1'b0)
         report_err("uart_irq_o", 64'(uart_irq), 64'd0);
      bus_read(ctrl_addr(CTRL_LED_OFS), w);
      if (w !== 64'd0)
         report_err("led readback", w, 64'd0);
      bus_read({3'(REGION_UART), 15'd0}, w);   // keyboard slot
      if (w !== 64'd0)
         report_err("region 6 low half", w, 64'd0);
      region = 3'($urandom_range(7));
      if (region == 3'(REGION_CTRL) || region == 3'(REGION_UART))
         region = 3'd0;
      bus_read({region, 15'($urandom)}, w);
      if (w !== 64'd0)
         report_err("unmapped region", w, 64'd0);
      end_test("after_reset");
   endtask

   task automatic test_ctrl();
      logic [63:0]      w;
      logic [63:0]      data;
      logic [DIP_W-1:0] dip;
      logic [4:0]       ofs;
      repeat (6)
      begin
         data  = {$urandom, $urandom};
         led_m = data[LED_W-1:0];
         bus_write(ctrl_addr(CTRL_LED_OFS), data);
         bus_read(ctrl_addr(CTRL_LED_OFS), w);
         if (w !== 64'(led_m))
            report_err("led readback", w, 64'(led_m));
         if (to_led !== led_m)
            report_err("to_led_o", 64'(to_led), 64'(led_m));
         dip      = DIP_W'($urandom);
         from_dip = dip;
         @(negedge msoc_clk);   // dip copy is registered
         bus_read(ctrl_addr(CTRL_DIP_OFS), w);
         if (w !== 64'(dip))
            report_err("dip readback", w, 64'(dip));
         ofs = 5'($urandom_range(30));
         if (ofs == CTRL_LED_OFS)
            ofs = 5'd0;
         bus_read(ctrl_addr(ofs), w);
         if (w !== 64'h0000_0000_dead_beef)
            report_err("unmapped ctrl word", w, 64'h0000_0000_dead_beef);
      end
      end_test("ctrl");
   endtask

   task automatic test_loopback();
      logic [BAUD_W-1:0] baud;
      logic [7:0]        b;
      int                n;
      baud = BAUD_W'($urandom_range(20, 8));
      n    = 6;
      bus_write(uart_addr(UART_SEL_BAUD), 64'(baud));
      for (int i = 0; i < n; i++)
      begin
         b = 8'($urandom);
         bus_write(uart_addr(UART_SEL_PUSH), {$urandom, 24'($urandom), b});
         rx_q.push_back({1'b0, b});
      end
      wait_rx_written(rx_wr_m + 12'(n), n * 12 * int'(baud) + 200);
      tx_wr_m = tx_wr_m + 12'(n);
      tx_rd_m = tx_rd_m + 12'(n);
      rx_wr_m = rx_wr_m + 12'(n);
      if (uart_irq !== 1'b1)
         report_err("uart_irq_o", 64'(uart_irq), 64'd1);
      drain_rx();
      end_test("loopback");
   endtask

   task automatic test_overflow();
      logic [63:0] w;
      int          accepted;
      force_bit  = 1'b1;
      force_mode = 1'b1;   // keep the receiver quiet
      bus_write(uart_addr(UART_SEL_BAUD), 64'd2000);
      for (int i = 0; i < 19; i++)
         bus_write(uart_addr(UART_SEL_PUSH), 64'($urandom));
      accepted = 1 + (1 << FIFO_DEPTH_LOG2);   // one in the serializer, the rest queued
      tx_wr_m  = tx_wr_m + 12'(accepted);
      tx_rd_m  = tx_rd_m + 12'd1;
      bus_read(uart_addr(2'b00), w);
      if (w[ST_TX_FULL_BIT] !== 1'b1)
         report_err("status tx full", 64'(w[ST_TX_FULL_BIT]), 64'd1);
      bus_read(uart_addr(2'b10), w);
      if (w !== count_word())
         report_err("count word", w, count_word());
      apply_reset();   // drop the slow backlog
      end_test("overflow");
   endtask

   task automatic test_framing();
      logic [7:0] b;
      bus_write(uart_addr(UART_SEL_BAUD), 64'(FRAME_BAUD));
      b = 8'($urandom);
      send_frame(b, 1'b0, FRAME_BAUD);   // stop bit low
      rx_q.push_back({1'b1, b});
      b = 8'($urandom);
      send_frame(b, 1'b1, FRAME_BAUD);
      rx_q.push_back({1'b0, b});
      wait_rx_written(rx_wr_m + 12'd2, 30 * FRAME_BAUD);
      rx_wr_m = rx_wr_m + 12'd2;
      drain_rx();
      end_test("framing");
   endtask

   initial
   begin
      void'($urandom(32'h26a4));
      rstn       = 1'b1;
      hid_en     = 1'b0;
      hid_we     = '0;
      hid_addr   = '0;
      hid_wrdata = '0;
      from_dip   = '0;
      force_mode = 1'b0;
      force_bit  = 1'b1;
      err_count  = 0;
      test_base  = 0;
      test_count = 0;
      bad_tests  = 0;
      @(negedge msoc_clk);   // reset starts on the first falling edge
      apply_reset();
      test_after_reset();
      test_ctrl();
      test_loopback();
      test_overflow();
      test_framing();
      $display("%0d tests run, %0d with errors, %0d errors in total, %0d assertion failures",
               test_count, bad_tests, err_count, uut.props.fail_count);
      if (err_count == 0 && uut.props.fail_count == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: flist.f
src/periph_map_pkg.sv
src/uart_pkg.sv
src/sync_fifo.sv
src/uart_core.sv
src/uart_ctrl.sv
src/periph_soc.sv
tb/periph_soc_properties.sv
tb/periph_soc_tb.sv

// File: Makefile
TOP := periph_soc_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f -o V$(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
